/* hw/isaPkg.sv */
package isaPkg;

	typedef logic [4:0] regIdx_t;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		SPECIAL = 6'b000000,
		REGIMM  = 6'b000001,
		J       = 6'b000010,
		JAL     = 6'b000011,
		BEQ     = 6'b000100,
		BNE     = 6'b000101,
		BLEZ    = 6'b000110,
		BGTZ    = 6'b000111,
		ADDI    = 6'b001000,
		ADDIU   = 6'b001001,
		SLTI    = 6'b001010,
		SLTIU   = 6'b001011,
		ANDI    = 6'b001100,
		ORI     = 6'b001101,
		XORI    = 6'b001110,
		LUI     = 6'b001111,
		BEQL    = 6'b010100,
		BNEL    = 6'b010101,
		BLEZL   = 6'b010110,
		BGTZL   = 6'b010111,
		LB      = 6'b100000,
		LH      = 6'b100001,
		LW      = 6'b100011,
		LBU     = 6'b100100,
		LHU     = 6'b100101,
		SB      = 6'b101000,
		SH      = 6'b101001,
		SW      = 6'b101011
	} opcode_t;

	// SPECIAL function field, instr[5:0]
	typedef enum logic [5:0] {
		F_SLL     = 6'b000000,
		F_SRL     = 6'b000010,
		F_SRA     = 6'b000011,
		F_SLLV    = 6'b000100,
		F_SRLV    = 6'b000110,
		F_SRAV    = 6'b000111,
		F_JR      = 6'b001000,
		F_JALR    = 6'b001001,
		F_SYSCALL = 6'b001100,
		F_BREAK   = 6'b001101,
		F_SYNC    = 6'b001111,
		F_MFHI    = 6'b010000,
		F_MTHI    = 6'b010001,
		F_MFLO    = 6'b010010,
		F_MTLO    = 6'b010011,
		F_MULT    = 6'b011000,
		F_MULTU   = 6'b011001,
		F_DIV     = 6'b011010,
		F_DIVU    = 6'b011011,
		F_ADD     = 6'b100000,
		F_ADDU    = 6'b100001,
		F_SUB     = 6'b100010,
		F_SUBU    = 6'b100011,
		F_AND     = 6'b100100,
		F_OR      = 6'b100101,
		F_XOR     = 6'b100110,
		F_NOR     = 6'b100111,
		F_SLT     = 6'b101010,
		F_SLTU    = 6'b101011
	} funct_t;

	// rt field under REGIMM, bit 1 marks the likely forms
	typedef enum logic [4:0] {
		BLTZ    = 5'b00000,
		BGEZ    = 5'b00001,
		BLTZL   = 5'b00010,
		BGEZL   = 5'b00011,
		BLTZAL  = 5'b10000,
		BGEZAL  = 5'b10001,
		BLTZALL = 5'b10010,
		BGEZALL = 5'b10011
	} regimmRt_t;

	typedef enum logic [4:0] {
		ExcNone = 5'd0,
		ExcSys  = 5'd8,
		ExcBp   = 5'd9,
		ExcRI   = 5'd10
	} excCode_t;

	typedef enum logic [1:0] {
		SignZero = 2'b00,
		SignPos  = 2'b01,
		SignNeg  = 2'b10
	} cmpSign_t;

	function automatic logic isLoad(input opcode_t op);
		return op inside {LB, LH, LW, LBU, LHU};
	endfunction

	function automatic logic isStore(input opcode_t op);
		return op inside {SB, SH, SW};
	endfunction

endpackage

/* hw/ctrlPkg.sv */
package ctrlPkg;

	// encodings follow the execute stage ALU
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		OR   = 5'd2,
		AND  = 5'd3,
		NOR  = 5'd4,
		XOR  = 5'd5,
		SLL  = 5'd6,
		SRL  = 5'd7,
		SRA  = 5'd8,
		SLT  = 5'd9,
		SLTU = 5'd10,
		ADDU = 5'd12,
		SUBU = 5'd16,
		NONE = 5'd31
	} aluOp_t;

	typedef enum logic [3:0] {
		MULTU = 4'd0,
		MULT  = 4'd1,
		DIVU  = 4'd2,
		DIV   = 4'd3
	} mdOp_t;

	typedef enum logic [1:0] {
		ZERO  = 2'd0,
		SIGN  = 2'd1,
		UPPER = 2'd2   // imm << 16
	} extOp_t;

	typedef enum logic [1:0] {
		SEQ    = 2'd0,
		BRANCH = 2'd1,
		JUMP   = 2'd2,
		JREG   = 2'd3
	} npcOp_t;

	typedef enum logic [1:0] {
		RT = 2'd0,
		RD = 2'd1,
		RA = 2'd2
	} dstSel_t;

	typedef enum logic [2:0] {
		HILO      = 3'd0,
		IMM_UPPER = 3'd1,
		ALU       = 3'd2,
		LINK      = 3'd3,
		MEM       = 3'd4
	} wbSel_t;

	typedef enum logic [2:0] {
		SB  = 3'd0,
		SH  = 3'd1,
		SW  = 3'd2,
		LBU = 3'd3,
		LB  = 3'd4,
		LHU = 3'd5,
		LH  = 3'd6,
		LW  = 3'd7
	} dmSel_t;

	typedef enum logic [1:0] {
		LO = 2'd0,
		HI = 2'd1,
		MD = 2'd2   // result pair from the mul/div unit
	} hiloWrSel_t;

endpackage

/* hw/instrIf.sv */
interface instrIf
	import isaPkg::*;
();
	opcode_t opcode;
	funct_t funct;
	regIdx_t rs;
	regIdx_t rt;
	logic [4:0] shamt;

	// decoders only look at the fields
	modport decoder (
		input opcode, funct, rs, rt, shamt
	);
endinterface

/* hw/writebackDecode.sv */
module writebackDecode
	import isaPkg::*, ctrlPkg::*;
(
	instrIf.decoder instr,
	output logic regWrite,
	output dstSel_t dstSel,
	output wbSel_t wbSel,
	output logic hiloWrite,
	output hiloWrSel_t hiloWrSel,
	output logic hiloRdHi,
	output logic hiloAccess,
	output logic mdStart
);
	logic isSpecial;
	logic linkRegimm;
	logic hiloRead;
	logic linkJump;

	assign isSpecial = instr.opcode == SPECIAL;
	assign linkJump = instr.opcode == JAL || instr.opcode == REGIMM;

	// only the linking REGIMM branches write back
	assign linkRegimm = instr.opcode == REGIMM &&
		instr.rt inside {BLTZAL, BGEZAL, BLTZALL, BGEZALL};

	always_comb begin
		case (instr.opcode)
			SPECIAL: regWrite = instr.funct inside {
				F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
				F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_SLT, F_SLTU,
				F_JALR, F_MFHI, F_MFLO};
			REGIMM: regWrite = linkRegimm;
			JAL, ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: regWrite = 1'b1;
			default: regWrite = isLoad(instr.opcode);
		endcase
	end

	always_comb begin
		if (isSpecial)
			dstSel = RD;
		else if (linkJump)
			dstSel = RA;   // $31
		else
			dstSel = RT;
	end

	always_comb begin
		wbSel = ALU;
		if (isSpecial) begin
			if (instr.funct == F_JALR)
				wbSel = LINK;
			else if (hiloRead)
				wbSel = HILO;
		end else if (instr.opcode == LUI)
			wbSel = IMM_UPPER;
		else if (linkJump)
			wbSel = LINK;   // pc + 8
		else if (isLoad(instr.opcode))
			wbSel = MEM;
	end

	assign mdStart = isSpecial && instr.funct inside {F_MULT, F_MULTU, F_DIV, F_DIVU};
	assign hiloRead = isSpecial && (instr.funct == F_MFHI || instr.funct == F_MFLO);
	assign hiloRdHi = isSpecial && instr.funct == F_MFHI;
	assign hiloWrite = mdStart ||
		(isSpecial && (instr.funct == F_MTHI || instr.funct == F_MTLO));
	assign hiloAccess = hiloWrite || hiloRead;   // any HI/LO traffic

	// mul/div result goes to both halves
	always_comb begin
		if (mdStart)
			hiloWrSel = MD;
		else if (isSpecial && instr.funct == F_MTHI)
			hiloWrSel = HI;
		else
			hiloWrSel = LO;
	end

endmodule

/* hw/memDecode.sv */
module memDecode
	import isaPkg::*, ctrlPkg::*;
(
	instrIf.decoder instr,
	output logic memWrite,
	output logic memRead,
	output dmSel_t dmSel
);
	assign memRead = isLoad(instr.opcode);
	assign memWrite = isStore(instr.opcode);

	// opcode and size names clash between the packages, so qualify both sides
	always_comb begin
		case (instr.opcode)
			isaPkg::SB: dmSel = ctrlPkg::SB;
			isaPkg::SH: dmSel = ctrlPkg::SH;
			isaPkg::SW: dmSel = ctrlPkg::SW;
			isaPkg::LBU: dmSel = ctrlPkg::LBU;
			isaPkg::LB: dmSel = ctrlPkg::LB;
			isaPkg::LHU: dmSel = ctrlPkg::LHU;
			isaPkg::LH: dmSel = ctrlPkg::LH;
			default: dmSel = ctrlPkg::LW;   // LW and every non-memory op
		endcase
	end

endmodule

/* hw/aluDecode.sv */
module aluDecode
	import isaPkg::*, ctrlPkg::*;
(
	instrIf.decoder instr,
	output aluOp_t aluOp,
	output mdOp_t mdOp,
	output logic shamtSel,
	output logic immSel,
	output extOp_t extOp
);
	logic isSpecial;
	logic isMem;

	assign isSpecial = instr.opcode == SPECIAL;
	assign isMem = isLoad(instr.opcode) || isStore(instr.opcode);

	always_comb begin
		aluOp = NONE;
		if (isSpecial) begin
			case (instr.funct)
				F_ADD: aluOp = ADD;
				F_ADDU: aluOp = ADDU;
				F_SUB: aluOp = SUB;
				F_SUBU: aluOp = SUBU;
				F_AND: aluOp = AND;
				F_OR: aluOp = OR;
				F_XOR: aluOp = XOR;
				F_NOR: aluOp = NOR;
				F_SLT: aluOp = SLT;
				F_SLTU: aluOp = SLTU;
				F_SLL, F_SLLV: aluOp = SLL;   // variable forms share the op
				F_SRL, F_SRLV: aluOp = SRL;
				F_SRA, F_SRAV: aluOp = SRA;
				default: aluOp = NONE;
			endcase
		end else begin
			case (instr.opcode)
				ADDI: aluOp = ADD;
				ADDIU: aluOp = ADDU;
				SLTI: aluOp = SLT;
				SLTIU: aluOp = SLTU;
				ANDI: aluOp = AND;
				ORI: aluOp = OR;
				XORI: aluOp = XOR;
				default: begin
					if (isMem)
						aluOp = ADD;   // address calc
				end
			endcase
		end
	end

	always_comb begin
		mdOp = MULTU;
		if (isSpecial) begin
			case (instr.funct)
				F_MULT: mdOp = MULT;
				F_DIVU: mdOp = DIVU;
				F_DIV: mdOp = DIV;
				default: mdOp = MULTU;
			endcase
		end
	end

	// fixed shifts take sa instead of rs
	assign shamtSel = isSpecial && instr.funct inside {F_SLL, F_SRL, F_SRA};
	assign immSel = !isSpecial;

	always_comb begin
		if (instr.opcode == LUI)
			extOp = UPPER;
		else if (isMem || instr.opcode inside {ADDI, ADDIU, SLTI, SLTIU})
			extOp = SIGN;
		else
			extOp = ZERO;   // logical immediates
	end

endmodule

/* hw/branchResolve.sv */
module branchResolve
	import isaPkg::*, ctrlPkg::*;
(
	instrIf.decoder instr,
	input logic cmpDiffer,
	input cmpSign_t cmpSign,
	output logic isBranch,
	output npcOp_t npcOp,
	output logic jump,
	output logic likelyFlush
);
	logic condBranch;
	logic taken;
	logic likely;
	logic jumpDirect;
	logic jumpReg;

	assign jumpDirect = instr.opcode == J || instr.opcode == JAL;
	assign jumpReg = instr.opcode == SPECIAL && instr.funct inside {F_JR, F_JALR};

	always_comb begin
		condBranch = 1'b1;
		taken = 1'b0;
		likely = 1'b0;
		case (instr.opcode)
			BEQ, BEQL: taken = !cmpDiffer;
			BNE, BNEL: taken = cmpDiffer;
			BLEZ: taken = cmpSign != SignPos;
			BGTZ: taken = cmpSign == SignPos;
			BLEZL: begin
				condBranch = instr.rt == '0;   // rt must be zero for the likely forms
				taken = condBranch && cmpSign != SignPos;
			end
			BGTZL: begin
				condBranch = instr.rt == '0;
				taken = condBranch && cmpSign == SignPos;
			end
			REGIMM: begin
				case (instr.rt)
					BGEZ, BGEZL, BGEZAL, BGEZALL: taken = cmpSign != SignNeg;
					BLTZ, BLTZL, BLTZAL, BLTZALL: taken = cmpSign == SignNeg;
					default: condBranch = 1'b0;
				endcase
				likely = instr.rt inside {BLTZL, BGEZL, BLTZALL, BGEZALL};
			end
			default: condBranch = 1'b0;
		endcase
		if (instr.opcode inside {BEQL, BNEL, BLEZL, BGTZL})
			likely = condBranch;
	end

	always_comb begin
		if (jumpDirect)
			npcOp = JUMP;
		else if (jumpReg)
			npcOp = JREG;
		else if (taken)
			npcOp = BRANCH;
		else
			npcOp = SEQ;
	end

	assign isBranch = condBranch || jumpDirect || jumpReg;
	assign jump = npcOp != SEQ;
	// untaken likely branch kills its delay slot
	assign likelyFlush = likely && !taken;

endmodule

/* hw/exceptionCheck.sv */
module exceptionCheck
	import isaPkg::*;
(
	input logic clk,
	input logic rst,
	instrIf.decoder instr,
	input logic regWrite,
	input logic hiloWrite,
	input logic memWrite,
	input logic isBranch,
	input logic ifFlush,
	input logic fetchExc,
	input excCode_t fetchExcCode,
	output logic idException,
	output excCode_t idExcCode
);
	logic postReset;
	logic isBreak;
	logic isSyscall;
	logic isSync;
	logic known;

	// held through reset, drops one cycle after release
	always_ff @(posedge clk) begin
		if (!rst)
			postReset <= 1'b1;
		else
			postReset <= 1'b0;
	end

	assign isBreak = instr.opcode == SPECIAL && instr.funct == F_BREAK;
	assign isSyscall = instr.opcode == SPECIAL && instr.funct == F_SYSCALL;
	assign isSync = instr.opcode == SPECIAL && instr.funct == F_SYNC;

	// anything the decoders claimed, plus ops with no side effect here
	assign known = regWrite || hiloWrite || memWrite || isBranch ||
		isBreak || isSyscall || isSync;

	always_comb begin
		idException = 1'b1;
		idExcCode = ExcNone;
		if (fetchExc)
			idExcCode = fetchExcCode;   // earlier stage wins
		else if (!known && !postReset && !ifFlush)
			idExcCode = ExcRI;
		else if (isBreak)
			idExcCode = ExcBp;
		else if (isSyscall)
			idExcCode = ExcSys;
		else
			idException = 1'b0;
	end

endmodule

/* hw/ctrlTop.sv */
module ctrlTop
	import isaPkg::*, ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [31:0] instr,
	input logic cmpDiffer,
	input cmpSign_t cmpSign,
	input logic ifFlush,
	input logic fetchExc,
	input excCode_t fetchExcCode,
	output logic regWrite,
	output dstSel_t dstSel,
	output wbSel_t wbSel,
	output logic hiloWrite,
	output hiloWrSel_t hiloWrSel,
	output logic hiloRdHi,
	output logic hiloAccess,
	output logic mdStart,
	output mdOp_t mdOp,
	output aluOp_t aluOp,
	output logic shamtSel,
	output logic immSel,
	output extOp_t extOp,
	output logic memWrite,
	output logic memRead,
	output dmSel_t dmSel,
	output npcOp_t npcOp,
	output logic jump,
	output logic isBranch,
	output logic likelyFlush,
	output logic idException,
	output excCode_t idExcCode
);
	instrIf instrFields();

	// rd and the immediate go straight to the datapath
	assign instrFields.opcode = opcode_t'(instr[31:26]);
	assign instrFields.rs = instr[25:21];
	assign instrFields.rt = instr[20:16];
	assign instrFields.shamt = instr[10:6];
	assign instrFields.funct = funct_t'(instr[5:0]);

	writebackDecode i_writebackDecode (
		.instr(instrFields),
		.regWrite(regWrite),
		.dstSel(dstSel),
		.wbSel(wbSel),
		.hiloWrite(hiloWrite),
		.hiloWrSel(hiloWrSel),
		.hiloRdHi(hiloRdHi),
		.hiloAccess(hiloAccess),
		.mdStart(mdStart)
	);

	memDecode i_memDecode (
		.instr(instrFields),
		.memWrite(memWrite),
		.memRead(memRead),
		.dmSel(dmSel)
	);

	aluDecode i_aluDecode (
		.instr(instrFields),
		.aluOp(aluOp),
		.mdOp(mdOp),
		.shamtSel(shamtSel),
		.immSel(immSel),
		.extOp(extOp)
	);

	branchResolve i_branchResolve (
		.instr(instrFields),
		.cmpDiffer(cmpDiffer),
		.cmpSign(cmpSign),
		.isBranch(isBranch),
		.npcOp(npcOp),
		.jump(jump),
		.likelyFlush(likelyFlush)
	);

	exceptionCheck i_exceptionCheck (
		.clk(clk),
		.rst(rst),
		.instr(instrFields),
		.regWrite(regWrite),
		.hiloWrite(hiloWrite),
		.memWrite(memWrite),
		.isBranch(isBranch),
		.ifFlush(ifFlush),
		.fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode),
		.idException(idException),
		.idExcCode(idExcCode)
	);

endmodule

/* tests/ctrlTop_assertions.sv */
module ctrlTopAssertions
	import ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic memWrite,
	input logic regWrite,
	input logic jump,
	input logic isBranch,
	input logic likelyFlush,
	input npcOp_t npcOp
);
	timeunit 1ns;
	timeprecision 100ps;

	// a store never writes the register file
	noStoreWriteback: assert property (@(posedge clk) disable iff (!rst)
		!(memWrite && regWrite))
		else $error("memWrite and regWrite high in the same cycle");

	jumpNeedsBranch: assert property (@(posedge clk) disable iff (!rst) jump |-> isBranch)
		else $error("jump high without isBranch");

	// flushed delay slot means fall-through
	flushMeansSeq: assert property (@(posedge clk) disable iff (!rst)
		likelyFlush |-> npcOp == SEQ)
		else $error("likelyFlush high while npcOp is not SEQ");

endmodule

bind ctrlTop ctrlTopAssertions i_ctrlTopAssertions (.*);

/* include/ctrlChecks.svh */
`ifndef CTRL_CHECKS_SVH
`define CTRL_CHECKS_SVH

// first mismatch ends the run
task automatic reportMismatch(input string what, input string got, input string exp);
	$display("ERROR: %s got %s expected %s at %0t", what, got, exp, $time);
	$display("SOME TESTS FAILED");
	$fatal(1, "compare failed");
endtask

task automatic checkAluOp(input string what, input aluOp_t got, input aluOp_t exp);
	if (got !== exp)
		reportMismatch(what, got.name(), exp.name());
endtask

task automatic checkNpcOp(input string what, input npcOp_t got, input npcOp_t exp);
	if (got !== exp)
		reportMismatch(what, got.name(), exp.name());
endtask

task automatic checkDstSel(input string what, input dstSel_t got, input dstSel_t exp);
	if (got !== exp)
		reportMismatch(what, got.name(), exp.name());
endtask

task automatic checkWbSel(input string what, input wbSel_t got, input wbSel_t exp);
	if (got !== exp)
		reportMismatch(what, got.name(), exp.name());
endtask

task automatic checkDmSel(input string what, input dmSel_t got, input dmSel_t exp);
	if (got !== exp)
		reportMismatch(what, got.name(), exp.name());
endtask

// fetch codes may lie outside the named set, print the number
task automatic checkExcCode(input string what, input excCode_t got, input excCode_t exp);
	if (got !== exp)
		reportMismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

task automatic checkBit(input string what, input logic got, input logic exp);
	if (got !== exp)
		reportMismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

`endif

/* tests/ctrlTb.sv */
module ctrlTb
	import isaPkg::*, ctrlPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 5;
	localparam int BranchReps = 6;
	localparam int UndefReps = 6;
	// reset release, alu, writeback, memory, branch, exception vectors
	localparam int NumVectors = 2 + 26 + 10 + 11 + (16 * BranchReps + 5) + (5 + 2 * UndefReps);
	localparam int Margin = 40;

	typedef enum {CondEq, CondNe, CondGez, CondLtz, CondLez, CondGtz} cond_t;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic cmpDiffer;
	cmpSign_t cmpSign;
	logic ifFlush;
	logic fetchExc;
	excCode_t fetchExcCode;
	logic regWrite;
	dstSel_t dstSel;
	wbSel_t wbSel;
	logic hiloWrite;
	hiloWrSel_t hiloWrSel;
	logic hiloRdHi;
	logic hiloAccess;
	logic mdStart;
	mdOp_t mdOp;
	aluOp_t aluOp;
	logic shamtSel;
	logic immSel;
	extOp_t extOp;
	logic memWrite;
	logic memRead;
	dmSel_t dmSel;
	npcOp_t npcOp;
	logic jump;
	logic isBranch;
	logic likelyFlush;
	logic idException;
	excCode_t idExcCode;

	ctrlTop i_ctrlTop (.*);

	`include "ctrlChecks.svh"

	task automatic checkExtOp(input string what, input extOp_t got, input extOp_t exp);
		if (got !== exp)
			reportMismatch(what, got.name(), exp.name());
	endtask

	task automatic checkMdOp(input string what, input mdOp_t got, input mdOp_t exp);
		if (got !== exp)
			reportMismatch(what, got.name(), exp.name());
	endtask

	task automatic checkHiloWrSel(input string what, input hiloWrSel_t got,
		input hiloWrSel_t exp);
		if (got !== exp)
			reportMismatch(what, got.name(), exp.name());
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		#((ResetCycles + NumVectors + Margin) * ClkPeriod);
		$display("watchdog timeout: the directed tests did not finish in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog");
	end

	// unused fields get random filler
	function automatic logic [31:0] rType(input funct_t funct, input logic [4:0] shamt);
		return {6'b000000, 5'($urandom), 5'($urandom), 5'($urandom), shamt, funct};
	endfunction

	function automatic logic [31:0] iType(input opcode_t op, input regIdx_t rt);
		return {op, 5'($urandom), rt, 16'($urandom)};
	endfunction

	function automatic logic opcodeDefined(input logic [5:0] op);
		return op inside {SPECIAL, REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ,
			BEQL, BNEL, BLEZL, BGTZL, ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
			isaPkg::LB, isaPkg::LH, isaPkg::LW, isaPkg::LBU, isaPkg::LHU,
			isaPkg::SB, isaPkg::SH, isaPkg::SW};
	endfunction

	function automatic logic [31:0] undefinedInstr();
		logic [5:0] op;
		op = 6'($urandom);
		while (opcodeDefined(op))
			op = 6'($urandom);
		return {op, 26'($urandom)};
	endfunction

	// branch outcome straight from the condition rules
	function automatic logic takenBy(input cond_t cond, input logic differ, input cmpSign_t sign);
		case (cond)
			CondEq: return !differ;
			CondNe: return differ;
			CondGez: return sign != SignNeg;
			CondLtz: return sign == SignNeg;
			CondLez: return sign != SignPos;
			default: return sign == SignPos;
		endcase
	endfunction

	task automatic applyFull(input logic [31:0] word, input logic differ, input cmpSign_t sign,
		input logic flush, input logic fexc, input excCode_t fcode);
		@(negedge clk);
		instr = word;
		cmpDiffer = differ;
		cmpSign = sign;
		ifFlush = flush;
		fetchExc = fexc;
		fetchExcCode = fcode;
		#1;   // settle before the rising edge
	endtask

	task automatic applyInstr(input logic [31:0] word);
		applyFull(word, 1'b0, SignZero, 1'b0, 1'b0, ExcNone);
	endtask

	task automatic resetTest();
		logic [31:0] word;
		word = undefinedInstr();
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		instr = word;
		#1;
		checkBit("idException (first cycle after reset)", idException, 1'b0);
		checkExcCode("idExcCode (first cycle after reset)", idExcCode, ExcNone);
		applyInstr(word);   // suppression is gone by now
		checkExcCode("idExcCode (after reset window)", idExcCode, ExcRI);
	endtask

	task automatic aluRCase(input funct_t f, input aluOp_t exp, input logic expShamt);
		applyInstr(rType(f, 5'($urandom)));
		checkAluOp({"aluOp (", f.name(), ")"}, aluOp, exp);
		checkBit({"shamtSel (", f.name(), ")"}, shamtSel, expShamt);
		checkBit({"immSel (", f.name(), ")"}, immSel, 1'b0);
	endtask

	task automatic aluICase(input opcode_t op, input aluOp_t exp, input extOp_t expExt);
		applyInstr(iType(op, 5'($urandom)));
		checkAluOp({"aluOp (", op.name(), ")"}, aluOp, exp);
		checkExtOp({"extOp (", op.name(), ")"}, extOp, expExt);
		checkBit({"immSel (", op.name(), ")"}, immSel, 1'b1);
		checkBit({"shamtSel (", op.name(), ")"}, shamtSel, 1'b0);
	endtask

	task automatic aluTest();
		aluRCase(F_ADD, ADD, 1'b0);
		aluRCase(F_ADDU, ADDU, 1'b0);
		aluRCase(F_SUB, SUB, 1'b0);
		aluRCase(F_SUBU, SUBU, 1'b0);
		aluRCase(F_AND, AND, 1'b0);
		aluRCase(F_OR, OR, 1'b0);
		aluRCase(F_XOR, XOR, 1'b0);
		aluRCase(F_NOR, NOR, 1'b0);
		aluRCase(F_SLT, SLT, 1'b0);
		aluRCase(F_SLTU, SLTU, 1'b0);
		aluRCase(F_SLL, SLL, 1'b1);
		aluRCase(F_SRL, SRL, 1'b1);
		aluRCase(F_SRA, SRA, 1'b1);
		aluRCase(F_SLLV, SLL, 1'b0);   // amount from rs
		aluRCase(F_SRLV, SRL, 1'b0);
		aluRCase(F_SRAV, SRA, 1'b0);
		aluICase(ADDI, ADD, SIGN);
		aluICase(ADDIU, ADDU, SIGN);
		aluICase(SLTI, SLT, SIGN);
		aluICase(SLTIU, SLTU, SIGN);
		aluICase(ANDI, AND, ZERO);
		aluICase(ORI, OR, ZERO);
		aluICase(XORI, XOR, ZERO);
		aluICase(LUI, NONE, UPPER);
		aluICase(isaPkg::LW, ADD, SIGN);
		aluICase(isaPkg::SW, ADD, SIGN);
	endtask

	task automatic writebackTest();
		applyInstr(iType(ADDI, 5'd3));
		checkBit("regWrite (ADDI)", regWrite, 1'b1);
		checkDstSel("dstSel (ADDI)", dstSel, RT);
		checkWbSel("wbSel (ADDI)", wbSel, ALU);
		applyInstr(rType(F_ADD, 5'd0));
		checkBit("regWrite (ADD)", regWrite, 1'b1);
		checkDstSel("dstSel (ADD)", dstSel, RD);
		checkBit("hiloWrite (ADD)", hiloWrite, 1'b0);
		checkBit("hiloAccess (ADD)", hiloAccess, 1'b0);
		checkBit("mdStart (ADD)", mdStart, 1'b0);
		applyInstr({JAL, 26'($urandom)});
		checkBit("regWrite (JAL)", regWrite, 1'b1);
		checkDstSel("dstSel (JAL)", dstSel, RA);
		checkWbSel("wbSel (JAL)", wbSel, LINK);
		applyInstr(iType(LUI, 5'd7));
		checkWbSel("wbSel (LUI)", wbSel, IMM_UPPER);
		applyInstr(iType(isaPkg::LW, 5'd9));
		checkWbSel("wbSel (LW)", wbSel, MEM);
		checkDstSel("dstSel (LW)", dstSel, RT);
		applyInstr(rType(F_MTHI, 5'd0));
		checkBit("hiloWrite (MTHI)", hiloWrite, 1'b1);
		checkHiloWrSel("hiloWrSel (MTHI)", hiloWrSel, HI);
		checkBit("regWrite (MTHI)", regWrite, 1'b0);
		applyInstr(rType(F_MTLO, 5'd0));
		checkHiloWrSel("hiloWrSel (MTLO)", hiloWrSel, LO);
		applyInstr(rType(F_DIV, 5'd0));
		checkBit("mdStart (DIV)", mdStart, 1'b1);
		checkHiloWrSel("hiloWrSel (DIV)", hiloWrSel, MD);
		checkMdOp("mdOp (DIV)", mdOp, DIV);
		checkBit("regWrite (DIV)", regWrite, 1'b0);
		applyInstr(rType(F_MFHI, 5'd0));
		checkBit("hiloRdHi (MFHI)", hiloRdHi, 1'b1);
		checkBit("hiloAccess (MFHI)", hiloAccess, 1'b1);
		checkWbSel("wbSel (MFHI)", wbSel, HILO);
		applyInstr(rType(F_MFLO, 5'd0));
		checkBit("hiloRdHi (MFLO)", hiloRdHi, 1'b0);
		checkWbSel("wbSel (MFLO)", wbSel, HILO);
	endtask

	task automatic memCase(input opcode_t op, input logic expRead, input logic expWrite,
		input dmSel_t expSel);
		applyInstr(iType(op, 5'($urandom)));
		checkBit({"memRead (", op.name(), ")"}, memRead, expRead);
		checkBit({"memWrite (", op.name(), ")"}, memWrite, expWrite);
		checkDmSel({"dmSel (", op.name(), ")"}, dmSel, expSel);
	endtask

	task automatic memTest();
		memCase(isaPkg::LB, 1'b1, 1'b0, ctrlPkg::LB);
		memCase(isaPkg::LBU, 1'b1, 1'b0, ctrlPkg::LBU);
		memCase(isaPkg::LH, 1'b1, 1'b0, ctrlPkg::LH);
		memCase(isaPkg::LHU, 1'b1, 1'b0, ctrlPkg::LHU);
		memCase(isaPkg::LW, 1'b1, 1'b0, ctrlPkg::LW);
		memCase(isaPkg::SB, 1'b0, 1'b1, ctrlPkg::SB);
		memCase(isaPkg::SH, 1'b0, 1'b1, ctrlPkg::SH);
		memCase(isaPkg::SW, 1'b0, 1'b1, ctrlPkg::SW);
		memCase(ADDI, 1'b0, 1'b0, ctrlPkg::LW);   // size falls back to word
		memCase(LUI, 1'b0, 1'b0, ctrlPkg::LW);
		memCase(BEQ, 1'b0, 1'b0, ctrlPkg::LW);
	endtask

	task automatic branchCase(input logic [31:0] word, input string label, input cond_t cond,
		input logic likely, input logic link);
		logic differ;
		cmpSign_t sign;
		logic taken;
		npcOp_t expNpc;
		repeat (BranchReps) begin
			differ = 1'($urandom);
			sign = cmpSign_t'(2'($urandom % 3));
			taken = takenBy(cond, differ, sign);
			expNpc = taken ? BRANCH : SEQ;
			applyFull(word, differ, sign, 1'b0, 1'b0, ExcNone);
			checkNpcOp({"npcOp (", label, ")"}, npcOp, expNpc);
			checkBit({"jump (", label, ")"}, jump, taken);
			checkBit({"likelyFlush (", label, ")"}, likelyFlush, likely && !taken);
			checkBit({"isBranch (", label, ")"}, isBranch, 1'b1);
			checkBit({"regWrite (", label, ")"}, regWrite, link);
		end
	endtask

	task automatic jumpCase(input logic [31:0] word, input string label, input npcOp_t exp);
		applyInstr(word);
		checkNpcOp({"npcOp (", label, ")"}, npcOp, exp);
		checkBit({"jump (", label, ")"}, jump, 1'b1);
		checkBit({"likelyFlush (", label, ")"}, likelyFlush, 1'b0);
	endtask

	task automatic branchTest();
		branchCase(iType(BEQ, 5'($urandom)), "BEQ", CondEq, 1'b0, 1'b0);
		branchCase(iType(BNE, 5'($urandom)), "BNE", CondNe, 1'b0, 1'b0);
		branchCase(iType(BLEZ, 5'd0), "BLEZ", CondLez, 1'b0, 1'b0);
		branchCase(iType(BGTZ, 5'd0), "BGTZ", CondGtz, 1'b0, 1'b0);
		branchCase(iType(BEQL, 5'($urandom)), "BEQL", CondEq, 1'b1, 1'b0);
		branchCase(iType(BNEL, 5'($urandom)), "BNEL", CondNe, 1'b1, 1'b0);
		branchCase(iType(BLEZL, 5'd0), "BLEZL", CondLez, 1'b1, 1'b0);
		branchCase(iType(BGTZL, 5'd0), "BGTZL", CondGtz, 1'b1, 1'b0);
		branchCase(iType(REGIMM, BLTZ), "BLTZ", CondLtz, 1'b0, 1'b0);
		branchCase(iType(REGIMM, BGEZ), "BGEZ", CondGez, 1'b0, 1'b0);
		branchCase(iType(REGIMM, BLTZL), "BLTZL", CondLtz, 1'b1, 1'b0);
		branchCase(iType(REGIMM, BGEZL), "BGEZL", CondGez, 1'b1, 1'b0);
		branchCase(iType(REGIMM, BLTZAL), "BLTZAL", CondLtz, 1'b0, 1'b1);
		branchCase(iType(REGIMM, BGEZAL), "BGEZAL", CondGez, 1'b0, 1'b1);
		branchCase(iType(REGIMM, BLTZALL), "BLTZALL", CondLtz, 1'b1, 1'b1);
		branchCase(iType(REGIMM, BGEZALL), "BGEZALL", CondGez, 1'b1, 1'b1);
		jumpCase({J, 26'($urandom)}, "J", JUMP);
		jumpCase({JAL, 26'($urandom)}, "JAL", JUMP);
		jumpCase(rType(F_JR, 5'd0), "JR", JREG);
		jumpCase(rType(F_JALR, 5'd0), "JALR", JREG);
		// likely LEZ form with rt set is not a branch
		applyInstr(iType(BLEZL, 5'd1 + 5'($urandom % 31)));
		checkBit("isBranch (BLEZL, rt nonzero)", isBranch, 1'b0);
		checkNpcOp("npcOp (BLEZL, rt nonzero)", npcOp, SEQ);
	endtask

	task automatic exceptionTest();
		logic [31:0] word;
		applyFull(rType(F_BREAK, 5'd0), 1'b0, SignZero, 1'b0, 1'b1, excCode_t'(5'd4));
		checkExcCode("idExcCode (fetch exc over BREAK)", idExcCode, excCode_t'(5'd4));
		checkBit("idException (fetch exc over BREAK)", idException, 1'b1);
		applyFull(undefinedInstr(), 1'b0, SignZero, 1'b0, 1'b1, excCode_t'(5'd6));
		checkExcCode("idExcCode (fetch exc over RI)", idExcCode, excCode_t'(5'd6));
		repeat (UndefReps) begin
			word = undefinedInstr();
			applyFull(word, 1'b0, SignZero, 1'b0, 1'b0, ExcNone);
			checkExcCode($sformatf("idExcCode (opcode %b)", word[31:26]), idExcCode, ExcRI);
			checkBit("idException (undefined opcode)", idException, 1'b1);
			applyFull(word, 1'b0, SignZero, 1'b1, 1'b0, ExcNone);
			checkBit("idException (undefined opcode, flushed)", idException, 1'b0);
		end
		applyInstr(rType(F_BREAK, 5'd0));
		checkExcCode("idExcCode (BREAK)", idExcCode, ExcBp);
		applyInstr(rType(F_SYSCALL, 5'd0));
		checkExcCode("idExcCode (SYSCALL)", idExcCode, ExcSys);
		applyInstr(rType(F_SYNC, 5'd0));
		checkBit("idException (SYNC)", idException, 1'b0);
	endtask

	initial begin
		void'($urandom(21006));
		rst = 1'b0;
		instr = '0;
		cmpDiffer = 1'b0;
		cmpSign = SignZero;
		ifFlush = 1'b0;
		fetchExc = 1'b0;
		fetchExcCode = ExcNone;
		resetTest();
		aluTest();
		writebackTest();
		memTest();
		branchTest();
		exceptionTest();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrIf.sv
hw/writebackDecode.sv
hw/memDecode.sv
hw/aluDecode.sv
hw/branchResolve.sv
hw/exceptionCheck.sv
hw/ctrlTop.sv
tests/ctrlTop_assertions.sv
tests/ctrlTb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module ctrlTb -o ctrlTbSim

./obj_dir/ctrlTbSim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
